/* verification/pecInput.txt */
# W weights (tap2..tap0, each chan3..chan0) weightFlags (tap2..tap0)
# A data (chan3..chan0) flags accum last; E address psum
W 03ff02020100fe0504030201 fff
A 01010101 f 0 0
A 03ff0002 f 0 0
A 0004fb0a f 0 0
A f80207fd f 0 0
A 06ec3264 f 0 1
E 0 00001d
E 1 000035
E 2 000139
A 01010101 f 1 0
A ffffffff f 1 0
A 02020202 f 1 0
A 01000100 f 1 1
E 0 00002f
E 1 000038
W 03ff02020100fe0504030201 7ef
A 01010101 f 0 0
A 03ff0002 b 0 0
W 000100000000010000000001 fff
A 0004fb0a f 0 0
A f80207fd 6 0 1
E 0 000013
E 1 000024
A 01010107 f 1 0
A 0101f701 f 1 0
A 01140101 f 1 1
E 0 000025

/* all.f */
hdl/pecPkg.sv
hdl/actStream.sv
hdl/psumReq.sv
hdl/weightConfig.sv
hdl/actRelay.sv
hdl/rowConvolver.sv
hdl/psumAccess.sv
hdl/pecCluster.sv
verification/pecClusterTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module pecClusterTb -f all.f -o pecClusterSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pecClusterSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

/* verification/pecClusterTb.sv */
`timescale 1ns/1ps

module pecClusterTb
    import pecPkg::*;
();

    // One line of the stimulus file, W or A
    typedef struct packed {
        logic [7:0] kind;
        weiArray_t  wei;
        weiFlags_t  weiFlag;
        actVec_t    act;
        flagVec_t   flag;
        logic       accum;
        logic       last;
    } stepRec_t;

    typedef struct packed {
        psumAddr_t addr;
        psum_t     data;
    } ramWrite_t;

    logic      clk;
    logic      rst_n;
    logic      weiValid;
    logic      weiReady;
    weiArray_t weiData;
    weiFlags_t weiFlag;
    logic      actValid;
    logic      actReady;
    actVec_t   actData;
    flagVec_t  actFlag;
    logic      actAccum;
    logic      actLast;
    logic      nxtValid;
    logic      nxtReady;
    actVec_t   nxtData;
    flagVec_t  nxtFlag;
    logic      nxtAccum;
    logic      nxtLast;
    logic      ramRdEn;
    psumAddr_t ramRdAddr;
    psum_t     ramRdData = '0;
    logic      ramWrEn;
    psumAddr_t ramWrAddr;
    psum_t     ramWrData;

    // Partial-sum RAM model, starts cleared
    psum_t ramMem [0:(1 << PsumAddrWidth) - 1] = '{default: '0};

    stepRec_t  steps[$];
    stepRec_t  fwdQueue[$];
    ramWrite_t expWrites[$];

    int          checkCount;
    int          errCount;
    int          timeoutCount;
    int unsigned waitLimit = 200;
    logic        timedOut;
    logic        rowBusy;
    logic        weiTaken;
    logic        colTaken;
    logic [15:0] lfsr;

    pecCluster pecCluster_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One-cycle read latency
    always @(posedge clk) begin
        if (ramRdEn) begin
            ramRdData <= ramMem[ramRdAddr];
        end
        if (ramWrEn) begin
            ramMem[ramWrAddr] <= ramWrData;
        end
    end

    // ========================================
    // Helpers
    // ========================================

    // Taps x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAct(input actVec_t gotData, input flagVec_t gotFlag,
                            input actVec_t expData, input flagVec_t expFlag);
        checkCount++;
        if (gotData !== expData || gotFlag !== expFlag) begin
            errCount++;
            $display("CHECK FAILED nxtData/nxtFlag got %h/%h expected %h/%h",
                     gotData, gotFlag, expData, expFlag);
        end
    endtask

    task automatic checkPsum(input string name, input psum_t got, input psum_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input psumAddr_t got, input psumAddr_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reportTimeout(input string what);
        timedOut = 1'b1;
        timeoutCount++;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    // Preload every line, expected writes go straight to their queue
    task automatic loadSteps();
        int        fd;
        int        n;
        string     line;
        string     rest;
        weiArray_t w;
        weiFlags_t wf;
        actVec_t   a;
        flagVec_t  f;
        logic      acc;
        logic      lst;
        psumAddr_t addr;
        psum_t     data;
        stepRec_t  rec;
        ramWrite_t wr;
        fd = $fopen("verification/pecInput.txt", "r");
        if (fd == 0) begin
            errCount++;
            $display("Could not open the stimulus file verification/pecInput.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            rest = line.substr(2, line.len() - 1);
            rec  = '0;
            rec.kind = line[0];
            case (line[0])
                "W": begin
                    n = $sscanf(rest, "%h %h", w, wf);
                    rec.wei     = w;
                    rec.weiFlag = wf;
                    steps.push_back(rec);
                end
                "A": begin
                    n = $sscanf(rest, "%h %h %h %h", a, f, acc, lst);
                    rec.act   = a;
                    rec.flag  = f;
                    rec.accum = acc;
                    rec.last  = lst;
                    steps.push_back(rec);
                end
                "E": begin
                    n = $sscanf(rest, "%h %h", addr, data);
                    wr.addr = addr;
                    wr.data = data;
                    expWrites.push_back(wr);
                end
                default: begin
                    n = 0;
                end
            endcase
            if (n < 2) begin
                errCount++;
                $display("Malformed line in stimulus file: %s", line);
            end
        end
        $fclose(fd);
    endtask

    // ========================================
    // Edge-level drive and sample
    // ========================================

    task automatic driveEdge();
        @(negedge clk);
        if (weiTaken) begin
            weiValid = 1'b0;
            weiTaken = 1'b0;
        end
        lfsr     = lfsrStep(lfsr);
        nxtReady = lfsr[0];
    endtask

    task automatic sampleEdge();
        stepRec_t seen;
        stepRec_t sent;
        ramWrite_t exp;
        @(posedge clk);
        // Weights must stay out while a row is open
        if (weiValid && weiReady) begin
            weiTaken = 1'b1;
            if (rowBusy) begin
                errCount++;
                $display("Weights were accepted in the middle of a row at %0t ns", $time);
            end
        end
        // Older column leaves before the new one is queued
        if (nxtValid && nxtReady) begin
            if (fwdQueue.size() == 0) begin
                errCount++;
                $display("A column was forwarded that was never accepted");
            end else begin
                seen = fwdQueue.pop_front();
                checkAct(nxtData, nxtFlag, seen.act, seen.flag);
                checkBit("nxtAccum", nxtAccum, seen.accum);
                checkBit("nxtLast", nxtLast, seen.last);
            end
        end
        if (actValid && actReady) begin
            sent       = '0;
            sent.act   = actData;
            sent.flag  = actFlag;
            sent.accum = actAccum;
            sent.last  = actLast;
            fwdQueue.push_back(sent);
            rowBusy  = !actLast;
            colTaken = 1'b1;
        end
        if (ramWrEn) begin
            if (expWrites.size() == 0) begin
                errCount++;
                $display("Unexpected RAM write to address %h", ramWrAddr);
            end else begin
                exp = expWrites.pop_front();
                checkAddr("ramWrAddr", ramWrAddr, exp.addr);
                checkPsum("ramWrData", ramWrData, exp.data);
            end
        end
    endtask

    task automatic idleCycle();
        driveEdge();
        actValid = 1'b0;
        sampleEdge();
    endtask

    // Holds off until a pending weight offer has gone in
    task automatic waitWeights();
        int unsigned waited;
        waited = 0;
        while (!timedOut && weiValid && !weiTaken) begin
            if (waited >= waitLimit) begin
                reportTimeout("weight load was never accepted");
                return;
            end
            idleCycle();
            waited++;
        end
    endtask

    task automatic offerWeights(input stepRec_t s);
        if (timedOut) begin
            return;
        end
        driveEdge();
        actValid = 1'b0;
        weiValid = 1'b1;
        weiData  = s.wei;
        weiFlag  = s.weiFlag;
        sampleEdge();
    endtask

    task automatic sendColumn(input stepRec_t s);
        int unsigned waited;
        if (timedOut) begin
            return;
        end
        waited = 0;
        driveEdge();
        actValid = 1'b1;
        actData  = s.act;
        actFlag  = s.flag;
        actAccum = s.accum;
        actLast  = s.last;
        colTaken = 1'b0;
        sampleEdge();
        while (!colTaken) begin
            if (waited >= waitLimit) begin
                reportTimeout("activation column was not accepted");
                return;
            end
            driveEdge();
            sampleEdge();
            waited++;
        end
    endtask

    task automatic drainOutputs();
        int unsigned waited;
        waited = 0;
        while (!timedOut && (fwdQueue.size() > 0 || expWrites.size() > 0)) begin
            if (waited >= waitLimit) begin
                reportTimeout("forwarded columns or RAM writes still outstanding");
                return;
            end
            idleCycle();
            waited++;
        end
        // Catch stray writes after the last expected one
        repeat (5) idleCycle();
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        stepRec_t step;
        rst_n        = 1'b0;
        weiValid     = 1'b0;
        weiData      = '0;
        weiFlag      = '0;
        actValid     = 1'b0;
        actData      = '0;
        actFlag      = '0;
        actAccum     = 1'b0;
        actLast      = 1'b0;
        nxtReady     = 1'b0;
        checkCount   = 0;
        errCount     = 0;
        timeoutCount = 0;
        timedOut     = 1'b0;
        rowBusy      = 1'b0;
        weiTaken     = 1'b0;
        colTaken     = 1'b0;
        lfsr         = 16'd62219;
        loadSteps();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Idle outputs right after reset
        checkBit("nxtValid", nxtValid, 1'b0);
        checkBit("ramRdEn", ramRdEn, 1'b0);
        checkBit("ramWrEn", ramWrEn, 1'b0);
        checkBit("weiReady", weiReady, 1'b1);
        checkAddr("ramRdAddr", ramRdAddr, '0);
        checkAddr("ramWrAddr", ramWrAddr, '0);
        sampleEdge();
        foreach (steps[i]) begin
            step = steps[i];
            if (step.kind == "W") begin
                waitWeights();
                offerWeights(step);
            end else begin
                // A new row only starts on settled weights
                if (!rowBusy) begin
                    waitWeights();
                end
                sendColumn(step);
            end
        end
        drainOutputs();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hdl/pecCluster.sv */
`timescale 1ns/1ps

module pecCluster
    import pecPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Weight load
    input  logic      weiValid,
    output logic      weiReady,
    input  weiArray_t weiData,
    input  weiFlags_t weiFlag,
    // Activations from previous cluster
    input  logic      actValid,
    output logic      actReady,
    input  actVec_t   actData,
    input  flagVec_t  actFlag,
    input  logic      actAccum,
    input  logic      actLast,
    // Activations to next cluster
    output logic      nxtValid,
    input  logic      nxtReady,
    output actVec_t   nxtData,
    output flagVec_t  nxtFlag,
    output logic      nxtAccum,
    output logic      nxtLast,
    // Partial-sum RAM
    output logic      ramRdEn,
    output psumAddr_t ramRdAddr,
    input  psum_t     ramRdData,
    output logic      ramWrEn,
    output psumAddr_t ramWrAddr,
    output psum_t     ramWrData
);

    // ========================================
    // Internal links
    // ========================================

    // Held kernel row
    weiArray_t weiQ;
    weiFlags_t weiFlagQ;
    logic      rowOpen;

    actStream convIf ();
    psumReq   dotIf ();

    // ========================================
    // Instances
    // ========================================

    weightConfig weightConfig_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .weiValid   (weiValid),
        .weiReady   (weiReady),
        .weiData    (weiData),
        .weiFlag    (weiFlag),
        .rowOpen    (rowOpen),
        .wei        (weiQ),
        .weiFlagOut (weiFlagQ)
    );

    actRelay actRelay_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .actValid (actValid),
        .actReady (actReady),
        .actData  (actData),
        .actFlag  (actFlag),
        .actAccum (actAccum),
        .actLast  (actLast),
        .nxtValid (nxtValid),
        .nxtReady (nxtReady),
        .nxtData  (nxtData),
        .nxtFlag  (nxtFlag),
        .nxtAccum (nxtAccum),
        .nxtLast  (nxtLast),
        .conv     (convIf.src)
    );

    rowConvolver rowConvolver_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .conv    (convIf.dst),
        .wei     (weiQ),
        .weiFlag (weiFlagQ),
        .rowOpen (rowOpen),
        .req     (dotIf.src)
    );

    psumAccess psumAccess_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (dotIf.dst),
        .ramRdEn   (ramRdEn),
        .ramRdAddr (ramRdAddr),
        .ramRdData (ramRdData),
        .ramWrEn   (ramWrEn),
        .ramWrAddr (ramWrAddr),
        .ramWrData (ramWrData)
    );

endmodule

/* hdl/psumAccess.sv */
`timescale 1ns/1ps

module psumAccess
    import pecPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    psumReq.dst       req,
    output logic      ramRdEn,
    output psumAddr_t ramRdAddr,
    input  psum_t     ramRdData,
    output logic      ramWrEn,
    output psumAddr_t ramWrAddr,
    output psum_t     ramWrData
);

    // Request waiting for its read word
    logic      s1Valid;
    psum_t     s1Sum;
    logic      s1Accum;
    logic      s1Last;

    logic      wrLast;
    psumAddr_t rdAddr;
    psumAddr_t wrAddr;

    // ========================================
    // Read side
    // ========================================

    // Fresh rows start from zero, no read
    assign ramRdEn   = req.dotValid && req.dotAccum;
    assign ramRdAddr = rdAddr;

    // Advances per output even when no read is issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdAddr <= '0;
        end else if (req.dotValid) begin
            if (req.dotLast) begin
                rdAddr <= '0;
            end else begin
                rdAddr <= rdAddr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1Valid <= 1'b0;
            ramWrEn <= 1'b0;
        end else begin
            s1Valid <= req.dotValid;
            ramWrEn <= s1Valid;
        end
    end

    // Sum rides along while the RAM answers
    always_ff @(posedge clk) begin
        if (req.dotValid) begin
            s1Sum   <= req.dotSum;
            s1Accum <= req.dotAccum;
            s1Last  <= req.dotLast;
        end
    end

    // ========================================
    // Accumulate and write back
    // ========================================

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            ramWrData <= s1Sum + (s1Accum ? ramRdData : psum_t'(0));
            wrLast    <= s1Last;
        end
    end

    assign ramWrAddr = wrAddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrAddr <= '0;
        end else if (ramWrEn) begin
            wrAddr <= wrLast ? '0 : wrAddr + 1'b1;  // row done, back to word 0
        end
    end

    // Write lands on the word it read
    assert property (@(posedge clk) disable iff (!rst_n)
        ramRdEn |-> ##2 (ramWrEn && (ramWrAddr == $past(ramRdAddr, 2))));

endmodule

/* hdl/rowConvolver.sv */
`timescale 1ns/1ps

module rowConvolver
    import pecPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    actStream.dst     conv,
    input  weiArray_t wei,
    input  weiFlags_t weiFlag,
    output logic      rowOpen,
    psumReq.src       req
);

    // Two older columns of the current row
    actVec_t   oldAct;
    flagVec_t  oldFlag;
    actVec_t   midAct;
    flagVec_t  midFlag;

    // Columns seen in this row, stops at three
    logic [1:0] colCnt;
    logic       rowActive;
    logic       winDone;

    // Window has the kernel row shape, tap 0 is the oldest column
    weiArray_t winAct;
    weiFlags_t winFlag;
    psum_t     winSum;

    assign winAct  = {conv.act, midAct, oldAct};
    assign winFlag = {conv.flag, midFlag, oldFlag};

    // Third or later column completes a window
    assign winDone = conv.valid && (colCnt >= 2'd2);

    // Includes the accepting cycle of the first column
    assign rowOpen = rowActive || conv.valid;

    // ========================================
    // Column history and row tracking
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            colCnt    <= 2'd0;
            rowActive <= 1'b0;
        end else if (conv.valid) begin
            rowActive <= !conv.last;
            if (conv.last) begin
                colCnt <= 2'd0;
            end else if (colCnt != 2'd3) begin
                colCnt <= colCnt + 2'd1;
            end
        end
    end

    // Shift on every column, stale entries masked by colCnt
    always_ff @(posedge clk) begin
        if (conv.valid) begin
            oldAct  <= midAct;
            oldFlag <= midFlag;
            midAct  <= conv.act;
            midFlag <= conv.flag;
        end
    end

    // ========================================
    // Masked dot product
    // ========================================

    always_comb begin
        logic signed [ProductWidth-1:0] prod;
        winSum = '0;
        prod   = '0;
        for (int k = 0; k < KernelTaps; k++) begin
            for (int j = 0; j < BlockDepth; j++) begin
                // Zero weight or zero activation drops the term
                if (weiFlag[k][j] && winFlag[k][j]) begin
                    prod   = $signed(wei[k][j]) * $signed(winAct[k][j]);
                    winSum = winSum + psum_t'(prod);
                end
            end
        end
    end

    // Result register, one cycle after the completing column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.dotValid <= 1'b0;
        end else begin
            req.dotValid <= winDone;
        end
    end

    always_ff @(posedge clk) begin
        if (winDone) begin
            req.dotSum   <= winSum;
            req.dotAccum <= conv.accum;
            req.dotLast  <= conv.last;
        end
    end

    // Upstream never closes a row before it holds a full window
    assert property (@(posedge clk) disable iff (!rst_n)
        (conv.valid && conv.last) |-> (colCnt >= 2'd2));

endmodule

/* hdl/actRelay.sv */
`timescale 1ns/1ps

module actRelay
    import pecPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // From previous cluster
    input  logic     actValid,
    output logic     actReady,
    input  actVec_t  actData,
    input  flagVec_t actFlag,
    input  logic     actAccum,
    input  logic     actLast,
    // To next cluster
    output logic     nxtValid,
    input  logic     nxtReady,
    output actVec_t  nxtData,
    output flagVec_t nxtFlag,
    output logic     nxtAccum,
    output logic     nxtLast,
    // Copy for the local convolver
    actStream.src    conv
);

    logic accept;

    // Slot free, or being drained this cycle
    assign actReady = !nxtValid || nxtReady;
    assign accept   = actValid && actReady;

    // ========================================
    // Forward register
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nxtValid <= 1'b0;
        end else if (accept) begin
            nxtValid <= 1'b1;
        end else if (nxtReady) begin
            nxtValid <= 1'b0;
        end
    end

    // Column payload, qualified by nxtValid
    always_ff @(posedge clk) begin
        if (accept) begin
            nxtData  <= actData;
            nxtFlag  <= actFlag;
            nxtAccum <= actAccum;
            nxtLast  <= actLast;
        end
    end

    // ========================================
    // Local copy
    // ========================================

    // Same cycle as the transfer, so the window closes on the accepting edge
    assign conv.valid = accept;
    assign conv.act   = actData;
    assign conv.flag  = actFlag;
    assign conv.accum = actAccum;
    assign conv.last  = actLast;

    // Held column stays put until the next cluster takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (nxtValid && !nxtReady) |=> (nxtValid && $stable(nxtData) && $stable(nxtFlag)));

endmodule

/* hdl/weightConfig.sv */
`timescale 1ns/1ps

module weightConfig
    import pecPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      weiValid,
    output logic      weiReady,
    input  weiArray_t weiData,
    input  weiFlags_t weiFlag,
    input  logic      rowOpen,
    output weiArray_t wei,
    output weiFlags_t weiFlagOut
);

    weiState_t state;
    weiState_t stateNext;
    logic      weiTake;

    // No loads while a row is in progress
    assign weiReady = (state != WeiLocked);
    assign weiTake  = weiValid && weiReady;

    // ========================================
    // State machine
    // ========================================

    always_comb begin
        stateNext = state;
        case (state)
            // A row can start before any load, it then sees zero weights
            WeiEmpty: begin
                if (rowOpen) begin
                    stateNext = WeiLocked;
                end else if (weiTake) begin
                    stateNext = WeiLoaded;
                end
            end
            WeiLoaded: begin
                if (rowOpen) begin
                    stateNext = WeiLocked;
                end
            end
            // Release once the last column has gone through
            WeiLocked: begin
                if (!rowOpen) begin
                    stateNext = WeiLoaded;
                end
            end
            default: stateNext = WeiEmpty;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= WeiEmpty;
            wei        <= '0;
            weiFlagOut <= '0;
        end else begin
            state <= stateNext;
            if (weiTake) begin
                wei        <= weiData;
                weiFlagOut <= weiFlag;
            end
        end
    end

    // Kernel stays fixed across consecutive cycles of an open row
    assert property (@(posedge clk) disable iff (!rst_n)
        (rowOpen && $past(rowOpen)) |-> ($stable(wei) && $stable(weiFlagOut)));

endmodule

/* hdl/psumReq.sv */
`timescale 1ns/1ps

// Registered row sum from the convolver to the RAM side
interface psumReq
    import pecPkg::*;
();

    logic  dotValid;
    psum_t dotSum;
    logic  dotAccum;
    logic  dotLast;

    modport src (output dotValid, dotSum, dotAccum, dotLast);

    modport dst (input dotValid, dotSum, dotAccum, dotLast);

endinterface

/* hdl/actStream.sv */
`timescale 1ns/1ps

// One accepted activation column, relay to convolver
// No ready, the convolver takes a column every cycle
interface actStream
    import pecPkg::*;
();

    // Single-cycle pulse per accepted column
    logic     valid;
    actVec_t  act;
    flagVec_t flag;
    // Add the stored partial sum
    logic     accum;
    // Closes the row
    logic     last;

    modport src (output valid, act, flag, accum, last);

    modport dst (input valid, act, flag, accum, last);

endinterface

/* hdl/pecPkg.sv */
package pecPkg;

    // ========================================
    // Sizes
    // ========================================

    // Element width of activations and weights
    localparam int DataWidth     = 8;
    // Channels carried in one activation column
    localparam int BlockDepth    = 4;
    // Taps in the single kernel row
    localparam int KernelTaps    = 3;
    // Full product of two elements
    localparam int ProductWidth  = 2 * DataWidth;
    // Partial sums leave room for 12 products plus accumulation
    localparam int PsumWidth     = 24;
    // Partial-sum RAM depth is 16 words
    localparam int PsumAddrWidth = 4;

    // ========================================
    // Data types
    // ========================================

    typedef logic signed [DataWidth-1:0] elem_t;

    // One column, channel 0 in the low byte
    typedef elem_t [BlockDepth-1:0] actVec_t;

    // Nonzero flag per channel
    typedef logic [BlockDepth-1:0] flagVec_t;

    // Kernel row, tap 0 in the low word
    typedef actVec_t [KernelTaps-1:0] weiArray_t;

    typedef flagVec_t [KernelTaps-1:0] weiFlags_t;

    typedef logic signed [PsumWidth-1:0] psum_t;

    typedef logic [PsumAddrWidth-1:0] psumAddr_t;

    // Weight register states
    // Locked covers the whole span of an open row
    typedef enum logic [1:0] {
        WeiEmpty,
        WeiLoaded,
        WeiLocked
    } weiState_t;

endpackage
